//--- axi_mem_model.f
+incdir+hw
hw/mem_pkg.sv
hw/mem_if.sv
hw/delay_lfsr.sv
hw/axi_read_port.sv
hw/axi_write_port.sv
hw/mem_core.sv
hw/axi_mem_model.sv
test/tb_axi_mem_model.sv

//--- hw/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module axi_mem_model (
    input  logic                      clock,
    input  logic                      reset,

    // instruction port
    input  logic [`MEM_ADDR_BITS-1:0] imem_araddr,
    input  logic                      imem_arvalid,
    output logic                      imem_arready,
    input  logic [7:0]                imem_arlen,
    input  logic [2:0]                imem_arsize,
    input  mem_pkg::burst_t           imem_arburst,
    output logic [`MEM_DATA_BITS-1:0] imem_rdata,
    output mem_pkg::resp_t            imem_rresp,
    output logic                      imem_rvalid,
    input  logic                      imem_rready,
    output logic                      imem_rlast,

    // data port, read side
    input  logic [`MEM_ADDR_BITS-1:0] dmem_araddr,
    input  logic                      dmem_arvalid,
    output logic                      dmem_arready,
    input  logic [7:0]                dmem_arlen,
    input  logic [2:0]                dmem_arsize,
    input  mem_pkg::burst_t           dmem_arburst,
    output logic [`MEM_DATA_BITS-1:0] dmem_rdata,
    output mem_pkg::resp_t            dmem_rresp,
    output logic                      dmem_rvalid,
    input  logic                      dmem_rready,
    output logic                      dmem_rlast,

    // data port, write side
    input  logic [`MEM_ADDR_BITS-1:0] dmem_awaddr,
    input  logic                      dmem_awvalid,
    output logic                      dmem_awready,
    input  logic [`MEM_DATA_BITS-1:0] dmem_wdata,
    input  logic [`MEM_STRB_BITS-1:0] dmem_wstrb,
    input  logic                      dmem_wvalid,
    output logic                      dmem_wready,
    output mem_pkg::resp_t            dmem_bresp,
    output logic                      dmem_bvalid,
    input  logic                      dmem_bready
);

    mem_rd_if imem_rd ();
    mem_rd_if dmem_rd ();
    mem_wr_if dmem_wr ();

    // distinct taps so the three delays do not track each other
    axi_read_port #(
        .LFSR_POLY (5'h12)
    ) imem_read_i (
        .clock   (clock),
        .reset   (reset),
        .araddr  (imem_araddr),
        .arvalid (imem_arvalid),
        .arready (imem_arready),
        .arlen   (imem_arlen),
        .arsize  (imem_arsize),
        .arburst (imem_arburst),
        .rdata   (imem_rdata),
        .rresp   (imem_rresp),
        .rvalid  (imem_rvalid),
        .rready  (imem_rready),
        .rlast   (imem_rlast),
        .mem     (imem_rd)
    );

    axi_read_port #(
        .LFSR_POLY (5'h14)
    ) dmem_read_i (
        .clock   (clock),
        .reset   (reset),
        .araddr  (dmem_araddr),
        .arvalid (dmem_arvalid),
        .arready (dmem_arready),
        .arlen   (dmem_arlen),
        .arsize  (dmem_arsize),
        .arburst (dmem_arburst),
        .rdata   (dmem_rdata),
        .rresp   (dmem_rresp),
        .rvalid  (dmem_rvalid),
        .rready  (dmem_rready),
        .rlast   (dmem_rlast),
        .mem     (dmem_rd)
    );

    axi_write_port #(
        .LFSR_POLY (5'h1e)
    ) dmem_write_i (
        .clock   (clock),
        .reset   (reset),
        .awaddr  (dmem_awaddr),
        .awvalid (dmem_awvalid),
        .awready (dmem_awready),
        .wdata   (dmem_wdata),
        .wstrb   (dmem_wstrb),
        .wvalid  (dmem_wvalid),
        .wready  (dmem_wready),
        .bresp   (dmem_bresp),
        .bvalid  (dmem_bvalid),
        .bready  (dmem_bready),
        .mem     (dmem_wr)
    );

    mem_core core_i (
        .clock   (clock),
        .imem_rd (imem_rd),
        .dmem_rd (dmem_rd),
        .wr      (dmem_wr)
    );

endmodule

`default_nettype wire

//--- hw/axi_read_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module axi_read_port #(
    parameter logic [`MEM_DELAY_BITS-1:0] LFSR_POLY = 5'h12
) (
    input  logic                      clock,
    input  logic                      reset,

    input  logic [`MEM_ADDR_BITS-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    input  logic [7:0]                arlen,
    input  logic [2:0]                arsize,
    input  mem_pkg::burst_t           arburst,

    output logic [`MEM_DATA_BITS-1:0] rdata,
    output mem_pkg::resp_t            rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      rlast,

    mem_rd_if.port_mp                 mem
);

    import mem_pkg::*;

    logic                       active;
    logic [`MEM_DELAY_BITS-1:0] wait_cnt;
    logic [`MEM_DELAY_BITS-1:0] delay;

    // burst state
    logic [`MEM_ADDR_BITS-1:0]  addr;
    logic [7:0]                 remaining;
    logic [2:0]                 size;
    burst_t                     burst;
    logic                       legal;

    logic [`MEM_ADDR_BITS-1:0]  next_addr;
    logic                       ar_fire;
    logic                       r_fire;
    logic                       advance;

    delay_lfsr #(
        .POLY (LFSR_POLY)
    ) lfsr_i (
        .clock (clock),
        .reset (reset),
        .value (delay)
    );

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign advance = r_fire && (remaining != 8'd0);

    // wrap is answered with an error, its data walks like incr
    assign next_addr = (burst == BURST_FIXED) ? addr
                                              : addr + (`MEM_ADDR_BITS'(1) << size);

    // first beat reads at the request, later beats at each handshake
    assign mem.rd_en   = ar_fire || advance;
    assign mem.rd_addr = ar_fire ? araddr : next_addr;

    assign arready = !active;
    assign rvalid  = active && (wait_cnt == '0);
    assign rlast   = rvalid && (remaining == 8'd0);
    assign rdata   = mem.rd_data;
    assign rresp   = (mem.rd_ok && legal) ? RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge clock) begin
        if (reset) begin
            active   <= 1'b0;
            wait_cnt <= '0;
        end else if (ar_fire) begin
            active   <= 1'b1;
            wait_cnt <= delay;
        end else if (advance) begin
            wait_cnt <= delay;
        end else if (r_fire) begin
            // last beat taken
            active <= 1'b0;
        end else if (active && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            addr      <= araddr;
            remaining <= arlen;
            size      <= arsize;
            burst     <= arburst;
            legal     <= ((arburst == BURST_FIXED) || (arburst == BURST_INCR)) &&
                         (arsize <= 3'(`MEM_MAX_SIZE));
        end else if (advance) begin
            addr      <= next_addr;
            remaining <= remaining - 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_write_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module axi_write_port #(
    parameter logic [`MEM_DELAY_BITS-1:0] LFSR_POLY = 5'h14
) (
    input  logic                      clock,
    input  logic                      reset,

    input  logic [`MEM_ADDR_BITS-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,

    input  logic [`MEM_DATA_BITS-1:0] wdata,
    input  logic [`MEM_STRB_BITS-1:0] wstrb,
    input  logic                      wvalid,
    output logic                      wready,

    output mem_pkg::resp_t            bresp,
    output logic                      bvalid,
    input  logic                      bready,

    mem_wr_if.port_mp                 mem
);

    import mem_pkg::*;

    logic                       aw_held;
    logic [`MEM_ADDR_BITS-1:0]  awaddr_q;
    logic                       b_active;
    logic [`MEM_DELAY_BITS-1:0] wait_cnt;
    logic [`MEM_DELAY_BITS-1:0] delay;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       b_fire;

    delay_lfsr #(
        .POLY (LFSR_POLY)
    ) lfsr_i (
        .clock (clock),
        .reset (reset),
        .value (delay)
    );

    // one write outstanding, address may arrive with its data
    assign awready = !aw_held && !b_active;
    assign wready  = (aw_held || aw_fire) && !b_active;
    assign bvalid  = b_active && (wait_cnt == '0);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    assign mem.wr_en   = w_fire;
    assign mem.wr_addr = aw_held ? awaddr_q : awaddr;
    assign mem.wr_data = wdata;
    assign mem.wr_strb = wstrb;

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_held <= 1'b0;
        end else if (w_fire) begin
            aw_held <= 1'b0;
        end else if (aw_fire) begin
            aw_held <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            b_active <= 1'b0;
            wait_cnt <= '0;
        end else if (w_fire) begin
            b_active <= 1'b1;
            wait_cnt <= delay;
        end else if (b_fire) begin
            b_active <= 1'b0;
        end else if (b_active && (wait_cnt != '0)) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            awaddr_q <= awaddr;
        end
        if (w_fire) begin
            bresp <= mem.wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- hw/delay_lfsr.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module delay_lfsr #(
    parameter logic [`MEM_DELAY_BITS-1:0] POLY = 5'h12
) (
    input  logic                       clock,
    input  logic                       reset,
    output logic [`MEM_DELAY_BITS-1:0] value
);

    // any nonzero seed works for a maximal polynomial
    localparam logic [`MEM_DELAY_BITS-1:0] SEED = 1;

    // galois form, shifts right and folds the taps back in
    always_ff @(posedge clock) begin
        if (reset) begin
            value <= SEED;
        end else if (value[0]) begin
            value <= (value >> 1) ^ POLY;
        end else begin
            value <= value >> 1;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module mem_core (
    input  logic      clock,
    mem_rd_if.core_mp imem_rd,
    mem_rd_if.core_mp dmem_rd,
    mem_wr_if.core_mp wr
);

    localparam int DEPTH  = 1 << `MEM_DEPTH_LOG2;
    localparam int OFS    = $clog2(`MEM_STRB_BITS);
    localparam int IDX_HI = `MEM_DEPTH_LOG2 + OFS - 1;

    logic [`MEM_DATA_BITS-1:0] ram [DEPTH];

    // addresses below the base wrap to a large offset and fail too
    function automatic logic in_window(input logic [`MEM_ADDR_BITS-1:0] addr);
        logic [`MEM_ADDR_BITS-1:0] offset;
        offset = addr - `MEM_BASE;
        return offset[`MEM_ADDR_BITS-1:IDX_HI+1] == '0;
    endfunction

    function automatic logic [`MEM_DATA_BITS-1:0] read_word(
        input logic [`MEM_ADDR_BITS-1:0] addr
    );
        return in_window(addr) ? ram[addr[IDX_HI:OFS]] : '0;
    endfunction

    assign wr.wr_ok = in_window(wr.wr_addr);

    // results hold until the next request
    always_ff @(posedge clock) begin
        if (imem_rd.rd_en) begin
            imem_rd.rd_ok   <= in_window(imem_rd.rd_addr);
            imem_rd.rd_data <= read_word(imem_rd.rd_addr);
        end
    end

    always_ff @(posedge clock) begin
        if (dmem_rd.rd_en) begin
            dmem_rd.rd_ok   <= in_window(dmem_rd.rd_addr);
            dmem_rd.rd_data <= read_word(dmem_rd.rd_addr);
        end
    end

    always_ff @(posedge clock) begin
        if (wr.wr_en && wr.wr_ok) begin
            for (int b = 0; b < `MEM_STRB_BITS; b++) begin
                if (wr.wr_strb[b]) begin
                    ram[wr.wr_addr[IDX_HI:OFS]][8*b +: 8] <= wr.wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

// read access, result is registered by the core
interface mem_rd_if;
    logic                      rd_en;
    logic [`MEM_ADDR_BITS-1:0] rd_addr;
    logic [`MEM_DATA_BITS-1:0] rd_data;
    logic                      rd_ok;

    modport port_mp (output rd_en, output rd_addr, input rd_data, input rd_ok);
    modport core_mp (input rd_en, input rd_addr, output rd_data, output rd_ok);
endinterface

// byte-masked write, wr_ok is combinational for wr_addr
interface mem_wr_if;
    logic                      wr_en;
    logic [`MEM_ADDR_BITS-1:0] wr_addr;
    logic [`MEM_DATA_BITS-1:0] wr_data;
    logic [`MEM_STRB_BITS-1:0] wr_strb;
    logic                      wr_ok;

    modport port_mp (
        output wr_en, output wr_addr, output wr_data, output wr_strb,
        input wr_ok
    );
    modport core_mp (
        input wr_en, input wr_addr, input wr_data, input wr_strb,
        output wr_ok
    );
endinterface

`default_nettype wire

//--- hw/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define MEM_ADDR_BITS 32
`define MEM_DATA_BITS 32
`define MEM_STRB_BITS 4

// memory window, 4 KiB of words starting at the base
`define MEM_BASE 32'h8000_0000
`define MEM_DEPTH_LOG2 10

// random response delay width
`define MEM_DELAY_BITS 5

// largest legal beat size code, four bytes
`define MEM_MAX_SIZE 2

`endif

//--- hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // AXI burst encoding
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    // only the two responses this memory gives
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_axi_mem_model -f axi_mem_model.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0

//--- test/tb_axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_params.svh"

module tb_axi_mem_model;

    import mem_pkg::*;

    localparam int WINDOW_BYTES = 4 << `MEM_DEPTH_LOG2;
    localparam int INIT_WORDS   = 128;
    localparam int ROUNDS       = 60;
    localparam int TRANSACTIONS = INIT_WORDS + 3 * ROUNDS;
    localparam int CYCLE_LIMIT  = TRANSACTIONS * 8 * 40;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] imem_araddr;
    logic        imem_arvalid;
    logic        imem_arready;
    logic [7:0]  imem_arlen;
    logic [2:0]  imem_arsize;
    burst_t      imem_arburst;
    logic [31:0] imem_rdata;
    resp_t       imem_rresp;
    logic        imem_rvalid;
    logic        imem_rready;
    logic        imem_rlast;
    logic [31:0] dmem_araddr;
    logic        dmem_arvalid;
    logic        dmem_arready;
    logic [7:0]  dmem_arlen;
    logic [2:0]  dmem_arsize;
    burst_t      dmem_arburst;
    logic [31:0] dmem_rdata;
    resp_t       dmem_rresp;
    logic        dmem_rvalid;
    logic        dmem_rready;
    logic        dmem_rlast;
    logic [31:0] dmem_awaddr;
    logic        dmem_awvalid;
    logic        dmem_awready;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wstrb;
    logic        dmem_wvalid;
    logic        dmem_wready;
    resp_t       dmem_bresp;
    logic        dmem_bvalid;
    logic        dmem_bready;

    // reference copy of the window with one entry per byte
    logic [7:0]  model [WINDOW_BYTES];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    axi_mem_model dut_i (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles without finishing the tests", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    function automatic bit in_window(input logic [31:0] addr);
        return (addr >= `MEM_BASE) && ((addr - `MEM_BASE) < WINDOW_BYTES);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int off;
        off = int'((addr - `MEM_BASE) & 32'hffff_fffc);
        return {model[off + 3], model[off + 2], model[off + 1], model[off]};
    endfunction

    function automatic logic [31:0] next_beat(input logic [31:0] addr, input logic [2:0] size,
                                              input burst_t burst);
        return (burst == BURST_FIXED) ? addr : addr + (32'd1 << size);
    endfunction

    // true when any beat of the burst lands on the word at waddr
    function automatic bit touches(input logic [31:0] addr, input logic [7:0] len,
                                   input logic [2:0] size, input burst_t burst,
                                   input logic [31:0] waddr);
        for (int k = 0; k <= int'(len); k++) begin
            if (addr[31:2] == waddr[31:2]) begin
                return 1'b1;
            end
            addr = next_beat(addr, size, burst);
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [31:0] word;
        word = 32'($urandom % 64) << 2;
        if ($urandom % 8 == 0) begin
            return 32'h4000_0000 + word;
        end
        return `MEM_BASE + word;
    endfunction

    function automatic logic [2:0] pick_size();
        if ($urandom % 8 == 0) begin
            return 3'd3;
        end
        return 3'($urandom % 3);
    endfunction

    function automatic burst_t pick_burst();
        int r;
        r = int'($urandom % 8);
        if (r == 0) begin
            return BURST_WRAP;
        end else if (r < 3) begin
            return BURST_FIXED;
        end
        return BURST_INCR;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int   gap;
        int   off;
        logic aw_left;
        logic w_left;
        logic fired;
        resp_t resp;
        gap = int'($urandom % 3);
        aw_left = 1'b1;
        w_left = 1'b1;
        dmem_awaddr = addr;
        dmem_wdata = data;
        dmem_wstrb = strb;
        // data may trail the address by a few cycles
        while (aw_left || w_left) begin
            // the port must use its held copy once the address is taken
            if (!aw_left) begin
                dmem_awaddr = ~addr;
            end
            dmem_awvalid = aw_left;
            dmem_wvalid = w_left && (gap == 0);
            @(negedge clock);
            if (dmem_awvalid && dmem_awready) begin
                aw_left = 1'b0;
            end
            if (dmem_wvalid && dmem_wready) begin
                w_left = 1'b0;
            end
            if (gap > 0) begin
                gap--;
            end
            next_cycle();
        end
        dmem_awvalid = 1'b0;
        dmem_wvalid = 1'b0;
        do begin
            dmem_bready = ($urandom % 4) != 0;
            @(negedge clock);
            fired = dmem_bvalid && dmem_bready;
            resp = dmem_bresp;
            next_cycle();
        end while (!fired);
        dmem_bready = 1'b0;
        check("bresp", 32'(in_window(addr) ? RESP_OKAY : RESP_SLVERR), 32'(resp));
        if (in_window(addr)) begin
            off = int'((addr - `MEM_BASE) & 32'hffff_fffc);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[off + b] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic read_burst(input bit on_dmem, input logic [31:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input burst_t burst);
        logic [31:0] beat_addr;
        logic [31:0] got_data;
        logic [31:0] want_data;
        resp_t       got_resp;
        resp_t       want_resp;
        logic        got_last;
        logic        ready;
        logic        fired;
        bit          legal;
        string       port;
        burst_t      other_burst;
        port = on_dmem ? "dmem" : "imem";
        legal = (burst != BURST_WRAP) && (size <= 3'd2);
        other_burst = (burst == BURST_FIXED) ? BURST_INCR : BURST_FIXED;
        if (on_dmem) begin
            dmem_araddr = addr;
            dmem_arlen = len;
            dmem_arsize = size;
            dmem_arburst = burst;
            dmem_arvalid = 1'b1;
        end else begin
            imem_araddr = addr;
            imem_arlen = len;
            imem_arsize = size;
            imem_arburst = burst;
            imem_arvalid = 1'b1;
        end
        do begin
            @(negedge clock);
            fired = on_dmem ? dmem_arready : imem_arready;
            next_cycle();
        end while (!fired);
        // the request is latched, so the bus payload is free to change
        if (on_dmem) begin
            dmem_arvalid = 1'b0;
            dmem_araddr = ~addr;
            dmem_arlen = ~len;
            dmem_arsize = ~size;
            dmem_arburst = other_burst;
        end else begin
            imem_arvalid = 1'b0;
            imem_araddr = ~addr;
            imem_arlen = ~len;
            imem_arsize = ~size;
            imem_arburst = other_burst;
        end
        beat_addr = addr;
        for (int beat = 0; beat <= int'(len); beat++) begin
            // random back-pressure on every beat
            do begin
                ready = ($urandom % 4) != 0;
                if (on_dmem) begin
                    dmem_rready = ready;
                end else begin
                    imem_rready = ready;
                end
                @(negedge clock);
                fired = ready && (on_dmem ? dmem_rvalid : imem_rvalid);
                got_data = on_dmem ? dmem_rdata : imem_rdata;
                got_resp = on_dmem ? dmem_rresp : imem_rresp;
                got_last = on_dmem ? dmem_rlast : imem_rlast;
                next_cycle();
            end while (!fired);
            want_data = in_window(beat_addr) ? model_word(beat_addr) : 32'd0;
            want_resp = (in_window(beat_addr) && legal) ? RESP_OKAY : RESP_SLVERR;
            check({port, " rdata"}, want_data, got_data);
            check({port, " rresp"}, 32'(want_resp), 32'(got_resp));
            check({port, " rlast"}, 32'(beat == int'(len)), 32'(got_last));
            beat_addr = next_beat(beat_addr, size, burst);
        end
        if (on_dmem) begin
            dmem_rready = 1'b0;
        end else begin
            imem_rready = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] fill_addr;
        logic [31:0] i_addr;
        logic [7:0]  i_len;
        logic [2:0]  i_size;
        burst_t      i_burst;
        logic [31:0] w_addr;
        logic [31:0] d_addr;
        logic [7:0]  d_len;
        logic [2:0]  d_size;
        burst_t      d_burst;
        void'($urandom(8145));
        reset = 1'b1;
        {imem_araddr, imem_arvalid, imem_arlen, imem_arsize, imem_rready} = '0;
        {dmem_araddr, dmem_arvalid, dmem_arlen, dmem_arsize, dmem_rready} = '0;
        {dmem_awaddr, dmem_awvalid, dmem_wdata, dmem_wstrb, dmem_wvalid, dmem_bready} = '0;
        imem_arburst = BURST_INCR;
        dmem_arburst = BURST_INCR;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        check("imem rvalid after reset", 32'd0, 32'(imem_rvalid));
        check("dmem rvalid after reset", 32'd0, 32'(dmem_rvalid));
        check("bvalid after reset", 32'd0, 32'(dmem_bvalid));
        check("imem arready after reset", 32'd1, 32'(imem_arready));
        check("dmem arready after reset", 32'd1, 32'(dmem_arready));
        check("awready after reset", 32'd1, 32'(dmem_awready));
        check("wready after reset", 32'd0, 32'(dmem_wready));

        // known contents for every word a burst can reach
        for (int w = 0; w < INIT_WORDS; w++) begin
            fill_addr = `MEM_BASE + 32'(w * 4);
            write_word(fill_addr, {fill_addr[15:0], fill_addr[31:16]} ^ 32'h9e37_79b9, 4'hf);
        end

        for (int r = 0; r < ROUNDS; r++) begin
            i_addr = pick_addr();
            i_len = 8'($urandom % 8);
            i_size = pick_size();
            i_burst = pick_burst();
            // the written word stays clear of the parallel instruction burst
            do begin
                d_addr = `MEM_BASE + (32'($urandom % 64) << 2);
            end while (touches(i_addr, i_len, i_size, i_burst, d_addr));
            w_addr = ($urandom % 8 == 0) ? (d_addr - `MEM_BASE + 32'h4000_0000) : d_addr;
            d_len = 8'($urandom % 8);
            d_size = pick_size();
            d_burst = pick_burst();
            fork
                read_burst(1'b0, i_addr, i_len, i_size, i_burst);
                begin
                    write_word(w_addr, $urandom, 4'($urandom % 16));
                    read_burst(1'b1, d_addr, d_len, d_size, d_burst);
                end
            join
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
